/* rtl/fifo_cfg_pkg.sv */
package fifo_cfg_pkg;

    // Memory addressing
    localparam int ADDR_BITS = 4;

    // Pointer carries one extra wrap bit to tell full from empty
    localparam int PTR_BITS = ADDR_BITS + 1;

    // Storage geometry
    localparam int DEPTH     = 16;
    localparam int DATA_BITS = 16;

    // almost_full when free slots drop to a quarter of the depth
    localparam int AF_THRESHOLD = DEPTH / 4;

    // almost_empty when stored entries drop to a quarter of the depth
    localparam int AE_THRESHOLD = DEPTH / 4;

endpackage

/* rtl/fifo_types_pkg.sv */
package fifo_types_pkg;

    import fifo_cfg_pkg::*;

    // Shared by binary and Gray pointers
    typedef logic [PTR_BITS-1:0]  ptr_t;
    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [DATA_BITS-1:0] data_t;

    // Write side flags
    typedef struct packed {
        logic full;
        logic almost_full;
    } wr_status_t;

    // Read side flags
    typedef struct packed {
        logic empty;
        logic almost_empty;
    } rd_status_t;

    function automatic ptr_t bin2gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // Each binary bit is the XOR of all Gray bits at or above it
    function automatic ptr_t gray2bin(input ptr_t gray);
        ptr_t bin;
        bin[PTR_BITS-1] = gray[PTR_BITS-1];
        for (int i = PTR_BITS - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

/* rtl/ptr_sync.sv */
`timescale 1ns/100ps

module ptr_sync (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fifo_types_pkg::ptr_t ptr_in,
    output fifo_types_pkg::ptr_t ptr_out
);

    import fifo_types_pkg::*;

    // First stage may go metastable and settles before the second stage samples
    ptr_t meta;

    // Gray coding keeps at most one bit in flight per source step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta    <= '0;
            ptr_out <= '0;
        end else begin
            meta    <= ptr_in;
            ptr_out <= meta;
        end
    end

endmodule

/* rtl/fifo_mem.sv */
`timescale 1ns/100ps

module fifo_mem (
    input  logic                  wclk,
    input  logic                  we,
    input  fifo_types_pkg::addr_t waddr,
    input  fifo_types_pkg::data_t wdata,
    input  fifo_types_pkg::addr_t raddr,
    output fifo_types_pkg::data_t rdata
);

    import fifo_cfg_pkg::*;
    import fifo_types_pkg::*;

    // Storage array, one word per entry
    data_t mem [DEPTH];

    // Write port lives in the wclk domain
    always_ff @(posedge wclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read port is asynchronous so the head word shows up with rd_valid.
    // The entry at raddr is stable here because the write side cannot
    // reach it until the read pointer has moved past and synchronized
    assign rdata = mem[raddr];

endmodule

/* rtl/write_pointer.sv */
`timescale 1ns/100ps

module write_pointer (
    input  logic                       wclk,
    input  logic                       rst_n,
    input  logic                       wen,
    input  fifo_types_pkg::ptr_t       rptr_sync,
    output fifo_types_pkg::ptr_t       waddr,
    output fifo_types_pkg::ptr_t       wptr,
    output fifo_types_pkg::wr_status_t wr_status
);

    import fifo_cfg_pkg::*;
    import fifo_types_pkg::*;

    ptr_t       next_waddr;
    ptr_t       next_wptr;
    ptr_t       rbin_sync;
    ptr_t       used;
    ptr_t       free_slots;
    wr_status_t next_status;

    // Increment only when the write is really accepted
    assign next_waddr = waddr + ptr_t'(wen && !wr_status.full);
    assign next_wptr  = bin2gray(next_waddr);

    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            waddr <= '0;
            wptr  <= '0;
        end else begin
            waddr <= next_waddr;
            wptr  <= next_wptr;
        end
    end

    // Full when the write pointer has lapped the read pointer once.
    // In Gray code that means the top two bits differ and the rest match
    assign next_status.full = (next_wptr == {~rptr_sync[PTR_BITS-1:PTR_BITS-2],
                                             rptr_sync[PTR_BITS-3:0]});

    // Occupancy as seen from this side, modulo the pointer range
    assign rbin_sync  = gray2bin(rptr_sync);
    assign used       = next_waddr - rbin_sync;
    assign free_slots = ptr_t'(DEPTH) - used;

    assign next_status.almost_full = (free_slots <= ptr_t'(AF_THRESHOLD));

    // Flags register on the same edge as the pointer
    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_status <= '0;
        end else begin
            wr_status <= next_status;
        end
    end

endmodule

/* rtl/read_pointer.sv */
`timescale 1ns/100ps

module read_pointer (
    input  logic                       rclk,
    input  logic                       rst_n,
    input  logic                       ren,
    input  fifo_types_pkg::ptr_t       wptr_sync,
    output fifo_types_pkg::ptr_t       raddr,
    output fifo_types_pkg::ptr_t       rptr,
    output fifo_types_pkg::rd_status_t rd_status
);

    import fifo_cfg_pkg::*;
    import fifo_types_pkg::*;

    ptr_t       next_raddr;
    ptr_t       next_rptr;
    ptr_t       wbin_sync;
    ptr_t       stored;
    rd_status_t next_status;

    // Pop only while something is there to pop
    assign next_raddr = raddr + ptr_t'(ren && !rd_status.empty);
    assign next_rptr  = bin2gray(next_raddr);

    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            raddr <= '0;
            rptr  <= '0;
        end else begin
            raddr <= next_raddr;
            rptr  <= next_rptr;
        end
    end

    // Empty when the read pointer catches up with the write pointer
    assign next_status.empty = (next_rptr == wptr_sync);

    // Stored words as seen from the read side
    assign wbin_sync = gray2bin(wptr_sync);
    assign stored    = wbin_sync - next_raddr;

    assign next_status.almost_empty = (stored <= ptr_t'(AE_THRESHOLD));

    // Out of reset the FIFO holds nothing, so both flags start high
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_status <= '1;
        end else begin
            rd_status <= next_status;
        end
    end

endmodule

/* rtl/async_fifo.sv */
`timescale 1ns/100ps

module async_fifo (
    // Write domain
    input  logic                       wclk,
    input  logic                       rst_n,
    input  logic                       wr_valid,
    input  fifo_types_pkg::data_t      wr_data,
    output logic                       wr_ready,
    output fifo_types_pkg::wr_status_t wr_status,

    // Read domain
    input  logic                       rclk,
    output logic                       rd_valid,
    output fifo_types_pkg::data_t      rd_data,
    input  logic                       rd_ready,
    output fifo_types_pkg::rd_status_t rd_status
);

    import fifo_cfg_pkg::*;
    import fifo_types_pkg::*;

    // Write domain pointers
    ptr_t waddr;
    ptr_t wptr;
    ptr_t rptr_sync;

    // Read domain pointers
    ptr_t raddr;
    ptr_t rptr;
    ptr_t wptr_sync;

    logic mem_we;

    // Handshake outputs come straight from the registered flags
    assign wr_ready = ~wr_status.full;
    assign rd_valid = ~rd_status.empty;

    // Memory only sees accepted writes
    assign mem_we = wr_valid & wr_ready;

    write_pointer u_write_pointer (
        .wclk      (wclk),
        .rst_n     (rst_n),
        .wen       (wr_valid),
        .rptr_sync (rptr_sync),
        .waddr     (waddr),
        .wptr      (wptr),
        .wr_status (wr_status)
    );

    read_pointer u_read_pointer (
        .rclk      (rclk),
        .rst_n     (rst_n),
        .ren       (rd_ready),
        .wptr_sync (wptr_sync),
        .raddr     (raddr),
        .rptr      (rptr),
        .rd_status (rd_status)
    );

    // Write pointer into the read domain
    ptr_sync u_wptr_sync (
        .clk     (rclk),
        .rst_n   (rst_n),
        .ptr_in  (wptr),
        .ptr_out (wptr_sync)
    );

    // Read pointer into the write domain
    ptr_sync u_rptr_sync (
        .clk     (wclk),
        .rst_n   (rst_n),
        .ptr_in  (rptr),
        .ptr_out (rptr_sync)
    );

    // Wrap bit is dropped on both memory addresses
    fifo_mem u_fifo_mem (
        .wclk  (wclk),
        .we    (mem_we),
        .waddr (waddr[ADDR_BITS-1:0]),
        .wdata (wr_data),
        .raddr (raddr[ADDR_BITS-1:0]),
        .rdata (rd_data)
    );

endmodule

/* dv/tb_async_fifo.sv */
`timescale 1ns/100ps

module tb_async_fifo;

    import fifo_cfg_pkg::*;
    import fifo_types_pkg::*;

    localparam int          WCLK_PERIOD     = 20;
    localparam int          RCLK_PERIOD     = 26;
    localparam int          RESET_CYCLES    = 4;
    localparam int          OVERFLOW_CYCLES = 6;
    localparam int          SETTLE_CYCLES   = 4;
    localparam int          NUM_ROWS        = 6;
    localparam logic [31:0] SEED            = 32'hef2a4b0c;

    // One test: word count, valid and ready odds in percent, fill before drain
    typedef struct packed {
        int words;
        int wr_pct;
        int rd_pct;
        bit wait_full;
    } row_t;

    row_t test_rows [NUM_ROWS] = '{
        '{DEPTH, 100, 100, 1'b1},
        '{40,    70,  50,  1'b0},
        '{40,    40,  90,  1'b0},
        '{DEPTH, 60,  80,  1'b1},
        '{60,    90,  30,  1'b0},
        '{24,    25,  25,  1'b0}
    };

    logic       wclk;
    logic       rclk;
    logic       rst_n;
    logic       wr_valid;
    data_t      wr_data;
    logic       wr_ready;
    wr_status_t wr_status;
    logic       rd_valid;
    data_t      rd_data;
    logic       rd_ready;
    rd_status_t rd_status;

    // Words accepted by the DUT and not yet read back
    data_t       model_q [$];
    logic [31:0] wr_rng;
    logic [31:0] rd_rng;
    bit          fill_done;
    int          errors;
    int          failed_tests;
    int          cycle_count;
    int          cycle_limit;

    async_fifo dut0 (
        .wclk      (wclk),
        .rst_n     (rst_n),
        .wr_valid  (wr_valid),
        .wr_data   (wr_data),
        .wr_ready  (wr_ready),
        .wr_status (wr_status),
        .rclk      (rclk),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .rd_ready  (rd_ready),
        .rd_status (rd_status)
    );

    always #(WCLK_PERIOD/2) wclk = ~wclk;
    always #(RCLK_PERIOD/2) rclk = ~rclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic log_error(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    // Write flags with reads held off and the read pointer settled
    task automatic check_write_flags(input int stored);
        if (wr_status.full !== (stored == DEPTH)) begin
            log_error($sformatf("full=%b with %0d words stored", wr_status.full, stored));
        end
        if (wr_status.almost_full !== (DEPTH - stored <= AF_THRESHOLD)) begin
            log_error($sformatf("almost_full=%b with %0d words stored",
                                wr_status.almost_full, stored));
        end
        if (wr_ready !== (stored != DEPTH)) begin
            log_error($sformatf("wr_ready=%b with %0d words stored", wr_ready, stored));
        end
    endtask

    // Read flags once every write has crossed over
    task automatic check_read_flags(input int stored);
        if (rd_valid !== (stored != 0)) begin
            log_error($sformatf("rd_valid=%b with %0d words stored", rd_valid, stored));
        end
        if (rd_status.almost_empty !== (stored <= AE_THRESHOLD)) begin
            log_error($sformatf("almost_empty=%b with %0d words stored",
                                rd_status.almost_empty, stored));
        end
    endtask

    task automatic write_side(input row_t r);
        int sent;
        int extra;
        sent  = 0;
        extra = 0;
        while (sent < r.words || (r.wait_full && extra < OVERFLOW_CYCLES)) begin
            @(posedge wclk);
            wr_rng = xorshift32(wr_rng);
            if (sent < r.words) begin
                wr_valid <= (wr_rng % 100) < r.wr_pct;
            end else begin
                // Keep pushing against a full FIFO
                wr_valid <= 1'b1;
                extra++;
            end
            wr_data <= wr_rng[31:16];
            @(negedge wclk);
            if (r.wait_full) begin
                check_write_flags(sent);
            end
            if (wr_valid && wr_ready) begin
                if (sent >= r.words) begin
                    log_error("write accepted while the FIFO was full");
                end
                // Model follows whatever the DUT accepted
                model_q.push_back(wr_data);
                sent++;
            end
        end
        @(posedge wclk);
        wr_valid <= 1'b0;
        if (r.wait_full && (sent != DEPTH || model_q.size() != DEPTH)) begin
            log_error($sformatf("%0d writes accepted before full, model holds %0d",
                                sent, model_q.size()));
        end
        fill_done = 1'b1;
    endtask

    task automatic read_side(input row_t r);
        int    got;
        bit    stalled;
        data_t held;
        data_t expected;
        got     = 0;
        stalled = 1'b0;
        held    = '0;
        if (r.wait_full) begin
            while (!fill_done) begin
                @(negedge rclk);
            end
        end
        while (got < r.words) begin
            @(posedge rclk);
            rd_rng = xorshift32(rd_rng);
            rd_ready <= (rd_rng % 100) < r.rd_pct;
            @(negedge rclk);
            if (r.wait_full) begin
                check_read_flags(model_q.size());
            end
            // Head word holds while the consumer stalls
            if (stalled && (rd_valid !== 1'b1 || rd_data !== held)) begin
                log_error($sformatf("head word moved during a stall, now %h", rd_data));
            end
            if (rd_valid && rd_ready) begin
                if (model_q.size() == 0) begin
                    log_error($sformatf("read %h that was never written", rd_data));
                end else begin
                    expected = model_q.pop_front();
                    if (rd_data !== expected) begin
                        log_error($sformatf("read %h, expected %h", rd_data, expected));
                    end
                end
                got++;
            end
            stalled = rd_valid && !rd_ready;
            held    = rd_data;
        end
        @(posedge rclk);
        rd_ready <= 1'b0;
        @(negedge rclk);
        if (rd_valid !== 1'b0 || rd_status.empty !== 1'b1) begin
            log_error($sformatf("rd_valid=%b after the last read", rd_valid));
        end
        if (rd_status.almost_empty !== 1'b1) begin
            log_error("almost_empty low after the last read");
        end
    endtask

    task automatic run_row(input int idx);
        row_t r;
        int   errors_before;
        r             = test_rows[idx];
        errors_before = errors;
        fill_done     = 1'b0;
        fork
            write_side(r);
            read_side(r);
        join
        if (model_q.size() != 0) begin
            log_error($sformatf("%0d words never came out", model_q.size()));
        end
        // Read pointer needs up to three wclk edges to cross back
        repeat (SETTLE_CYCLES) @(posedge wclk);
        @(negedge wclk);
        if (wr_ready !== 1'b1 || wr_status.almost_full !== 1'b0) begin
            log_error("write side does not see an empty FIFO after the drain");
        end
        if (errors == errors_before) begin
            $display("Test %0d: %0d words, wr %0d%%, rd %0d%%, ok",
                     idx, r.words, r.wr_pct, r.rd_pct);
        end else begin
            failed_tests++;
            $display("Test %0d: %0d words, wr %0d%%, rd %0d%%, %0d errors",
                     idx, r.words, r.wr_pct, r.rd_pct, errors - errors_before);
        end
    endtask

    task automatic check_reset_state();
        int errors_before;
        errors_before = errors;
        if (wr_ready !== 1'b1 || wr_status !== 2'b00) begin
            log_error($sformatf("write side after reset: wr_ready=%b full=%b almost_full=%b",
                                wr_ready, wr_status.full, wr_status.almost_full));
        end
        if (rd_valid !== 1'b0 || rd_status !== 2'b11) begin
            log_error($sformatf("read side after reset: rd_valid=%b empty=%b almost_empty=%b",
                                rd_valid, rd_status.empty, rd_status.almost_empty));
        end
        if (errors == errors_before) begin
            $display("Test reset: ok");
        end else begin
            failed_tests++;
            $display("Test reset: %0d errors", errors - errors_before);
        end
    endtask

    // Run limit scales with the words in the table
    initial begin
        int total;
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += test_rows[i].words;
        end
        cycle_limit = 8 * total + 200;
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge wclk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d wclk cycles", cycle_limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        wclk         = 1'b0;
        rclk         = 1'b0;
        rst_n        = 1'b0;
        wr_valid     = 1'b0;
        wr_data      = '0;
        rd_ready     = 1'b0;
        wr_rng       = SEED;
        rd_rng       = SEED ^ 32'h9e3779b9;
        fill_done    = 1'b0;
        errors       = 0;
        failed_tests = 0;

        repeat (RESET_CYCLES) @(posedge wclk);
        rst_n <= 1'b1;
        @(negedge wclk);
        check_reset_state();

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        $display("Tests: %0d, failed tests: %0d, errors: %0d",
                 NUM_ROWS + 1, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* async_fifo.f */
rtl/fifo_cfg_pkg.sv
rtl/fifo_types_pkg.sv
rtl/ptr_sync.sv
rtl/fifo_mem.sv
rtl/write_pointer.sv
rtl/read_pointer.sv
rtl/async_fifo.sv
dv/tb_async_fifo.sv

/* run_sim.sh */
#!/bin/sh
# Build the async_fifo testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=tb_async_fifo
LOG_FILE=sim.log

verilator --binary --timing \
    -f async_fifo.f \
    --top-module tb_async_fifo \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

if [ ! -x "$BUILD_DIR/$SIM_BIN" ]; then
    echo "Simulation binary $BUILD_DIR/$SIM_BIN was not produced"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The run only counts as passing when the testbench said so
if grep -q "^Simulation completed successfully$" "$LOG_FILE"; then
    echo "run_sim: PASS"
    exit 0
else
    echo "run_sim: FAIL, see $LOG_FILE"
    exit 1
fi
